//--- ex_stage.f
ex_pkg.sv
ex_alu.sv
ex_branch.sv
ex_div.sv
ex_mc_ctrl.sv
ex_mem_reg.sv
ex_stage.sv
tb_ex_stage.sv

//--- ex_trace.txt
# mode asrc bimm ainstr f3 f7b5 opb5 br jal jalr tsrc mc regw trap tcode rd rs1 rs2 imm pc
# then pc_sel tgt alu m_result trap trap_code; mode 0 normal 1 stall 2 flush 3 flush in divide
0 0 0 2 0 0 1 0 0 0 0 0 1 0 3 01 5 7 10 100 0 110 c 0 0 3
0 0 0 2 0 1 1 0 0 0 0 0 1 0 0 02 5 7 10 100 0 110 fffffffe 0 0 0
0 0 1 2 0 1 0 0 0 0 0 0 1 1 2 03 20 0 fffffff0 100 0 f0 10 0 1 2
0 0 0 2 1 0 1 0 0 0 0 0 1 0 0 04 1 24 0 200 0 200 10 0 0 0
0 0 1 2 2 0 0 0 0 0 0 0 1 0 0 05 ffffffff 0 1 200 0 201 1 0 0 0
0 0 0 2 3 0 1 0 0 0 0 0 1 0 0 06 ffffffff 1 0 200 0 200 0 0 0 0
2 0 0 2 4 0 1 0 0 0 0 0 1 0 0 07 f0f0 ff00 0 200 0 200 ff0 0 0 0
0 0 1 2 5 1 0 0 0 0 0 0 1 0 0 08 80000000 0 4 200 0 204 f8000000 0 0 0
0 1 1 2 6 0 0 0 0 0 0 0 1 0 0 09 ffff 0 123 200 0 323 123 0 0 0
0 2 0 2 7 0 1 0 0 0 0 0 1 0 0 0a 0 ff 0 234 0 234 34 0 0 0
0 3 1 0 5 1 1 0 0 0 0 0 1 0 0 0b 1000 0 8 200 0 208 1008 0 0 0
0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 00 5 5 40 300 2 340 a 0 0 0
0 0 0 0 1 0 1 1 0 0 0 0 0 0 0 00 5 5 40 300 0 340 a 0 0 0
0 0 0 0 4 0 1 1 0 0 0 0 0 0 0 00 ffffffff 1 40 300 2 340 0 0 0 0
0 0 0 0 5 0 1 1 0 0 0 0 0 0 0 00 1 ffffffff 40 300 2 340 0 0 0 0
0 0 0 0 6 0 1 1 0 0 0 0 0 0 3 00 ffffffff 1 42 300 0 342 0 0 0 3
0 0 0 0 7 0 1 1 0 0 0 0 0 0 3 00 ffffffff 1 42 300 2 342 0 0 1 0
0 2 0 0 0 0 1 0 1 0 0 0 1 0 0 01 0 4 80 400 2 480 404 0 0 0
0 0 1 0 0 0 1 0 0 1 1 0 1 0 0 01 1001 0 10 400 2 1010 1011 0 0 0
0 0 1 0 0 0 1 0 0 1 1 0 1 0 1 01 1002 0 0 400 2 1002 1002 0 1 0
0 0 0 0 5 0 1 0 0 0 0 1 1 0 0 0a 100 7 0 500 0 500 107 24 0 0
1 0 0 0 4 0 1 0 0 0 0 1 1 0 0 0b ffffff9c 7 0 500 0 500 ffffffa3 fffffff2 0 0
3 0 0 0 6 0 1 0 0 0 0 1 1 0 0 0c ffffff9c 7 0 500 0 500 ffffffa3 fffffffe 0 0
1 0 0 0 7 0 1 0 0 0 0 1 1 0 0 0d ffffff9c 7 0 500 0 500 ffffffa3 2 0 0
0 0 0 0 4 0 1 0 0 0 0 1 1 0 0 0e ffffff9c 0 0 500 0 500 ffffff9c ffffffff 0 0
0 0 0 0 6 0 1 0 0 0 0 1 1 0 0 0f ffffff9c 0 0 500 0 500 ffffff9c ffffff9c 0 0
1 0 0 0 4 0 1 0 0 0 0 1 1 0 0 10 80000000 ffffffff 0 500 0 500 7fffffff 80000000 0 0
3 0 0 0 6 0 1 0 0 0 0 1 1 0 0 11 80000000 ffffffff 0 500 0 500 7fffffff 0 0 0

//--- tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

  // Trace modes
  localparam int MODE_NORMAL    = 0;
  localparam int MODE_STALL     = 1;
  localparam int MODE_FLUSH     = 2;
  localparam int MODE_FLUSH_DIV = 3;

  localparam int MAX_ROWS = 64;
  localparam int NCOL     = 26;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                s_valid_i;
  logic                stall_i;
  logic                flush_i;
  logic                reg_write_i;
  ex_pkg::alu_a_src_t  alu_a_src_i;
  logic                alu_b_imm_i;
  ex_pkg::alu_instr_t  alu_instr_i;
  ex_pkg::funct3_t     funct3_i;
  logic                funct7_b5_i;
  logic                op_b5_i;
  logic                is_branch_i;
  logic                is_jal_i;
  logic                is_jalr_i;
  logic                jb_tgt_src_i;
  logic                is_mc_i;
  logic                trap_i;
  ex_pkg::trap_code_t  trap_code_i;
  ex_pkg::reg_addr_t   rd_i;
  ex_pkg::xlen_t       rs1_data_i;
  ex_pkg::xlen_t       rs2_data_i;
  ex_pkg::xlen_t       imm_i;
  ex_pkg::xlen_t       pc_i;
  ex_pkg::pc_sel_t     pc_sel_o;
  ex_pkg::xlen_t       pc_redir_tgt_o;
  logic                op_active_o;
  logic                m_valid_o;
  logic                reg_write_mem_o;
  logic                trap_mem_o;
  ex_pkg::trap_code_t  trap_code_mem_o;
  ex_pkg::reg_addr_t   rd_mem_o;
  ex_pkg::xlen_t       alu_result_mem_o;
  ex_pkg::xlen_t       m_result_mem_o;
  ex_pkg::xlen_t       jb_tgt_mem_o;

  // Trace rows with one column per field of a trace line
  logic [31:0] rows [0:MAX_ROWS-1][0:NCOL-1];
  int          n_rows      = 0;
  int          errors      = 0;
  int          checks      = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;
  logic [31:0] lfsr        = 32'ha53edabb;

  ex_stage ex_stage_i (.*);

  always #2 clk = ~clk;

  // Run limit scaled from the trace length once it is known
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Three LFSR bits per stall length
  function automatic int random_stall_len();
    int len;
    len = 0;
    for (int b = 0; b < 3; b++) begin
      lfsr = lfsr_next(lfsr);
      len  = (len << 1) | int'(lfsr[0]);
    end
    return len;
  endfunction

  task automatic check(input int row, input string field,
                       input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: row %0d %s expected %h actual %h", row, field, exp, act);
    end
  endtask

  task automatic read_trace();
    int          fd;
    int          got;
    string       line;
    logic [31:0] f [0:NCOL-1];
    fd = $fopen("ex_trace.txt", "r");
    if (fd == 0) begin
      $display("Trace file ex_trace.txt could not be opened");
      errors++;
    end else begin
      while (!$feof(fd) && n_rows < MAX_ROWS) begin
        got = $fgets(line, fd);
        // Blank and comment lines carry no operation
        if (got > 1 && line.substr(0, 0) != "#") begin
          got = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                        f[17], f[18], f[19], f[20], f[21], f[22], f[23], f[24],
                        f[25]);
          if (got == NCOL) begin
            for (int k = 0; k < NCOL; k++) begin
              rows[n_rows][k] = f[k];
            end
            n_rows++;
          end else begin
            $display("Trace line could not be parsed: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Stimulus fields of one trace row onto the DUT inputs
  task automatic drive_row(input int r);
    alu_a_src_i  = rows[r][1][1:0];
    alu_b_imm_i  = rows[r][2][0];
    alu_instr_i  = rows[r][3][1:0];
    funct3_i     = rows[r][4][2:0];
    funct7_b5_i  = rows[r][5][0];
    op_b5_i      = rows[r][6][0];
    is_branch_i  = rows[r][7][0];
    is_jal_i     = rows[r][8][0];
    is_jalr_i    = rows[r][9][0];
    jb_tgt_src_i = rows[r][10][0];
    is_mc_i      = rows[r][11][0];
    reg_write_i  = rows[r][12][0];
    trap_i       = rows[r][13][0];
    trap_code_i  = rows[r][14][1:0];
    rd_i         = rows[r][15][4:0];
    rs1_data_i   = rows[r][16];
    rs2_data_i   = rows[r][17];
    imm_i        = rows[r][18];
    pc_i         = rows[r][19];
  endtask

  // ==========================================================================
  // One operation from presentation to the registered result
  // ==========================================================================

  task automatic run_row(input int r);
    int   mode;
    logic is_div;
    logic seen;
    logic was_stalled;
    logic late_stall;
    int   stall_left;
    int   wait_limit;
    int   n;
    mode       = int'(rows[r][0][3:0]);
    is_div     = rows[r][11][0];
    seen       = 1'b0;
    late_stall = is_div && (mode == MODE_STALL);
    stall_left = (mode == MODE_STALL) ? random_stall_len() : 0;
    wait_limit = is_div ? ex_pkg::DIV_CYCLES + 24 : 3;
    n          = 0;

    // Accepted cycle where the redirect is combinational
    @(posedge clk);
    #1;
    drive_row(r);
    // A trap on the flushed operation shows whether the bubble reaches trap_mem_o
    if (mode == MODE_FLUSH) begin
      trap_i = 1'b1;
    end
    s_valid_i = 1'b1;
    flush_i   = (mode == MODE_FLUSH);
    @(negedge clk);
    check(r + 1, "pc_sel_o", rows[r][20], pc_sel_o);
    check(r + 1, "pc_redir_tgt_o", rows[r][21], pc_redir_tgt_o);
    check(r + 1, "op_active_o at start", is_div, op_active_o);

    while (!seen && n < wait_limit) begin
      @(posedge clk);
      #1;
      was_stalled = stall_i;
      // Once busy has fallen a second stall covers the completion cycle
      if (late_stall && stall_left == 0 && !op_active_o) begin
        stall_left = random_stall_len() + 1;
        late_stall = 1'b0;
      end
      s_valid_i = 1'b0;
      flush_i   = (mode == MODE_FLUSH_DIV);
      stall_i   = (stall_left > 0);
      if (stall_left > 0) begin
        stall_left--;
      end
      @(negedge clk);
      n++;
      // Divider stays busy for DIV_CYCLES cycles from the start edge
      if (is_div && n <= ex_pkg::DIV_CYCLES) begin
        check(r + 1, "op_active_o during divide", 1, op_active_o);
      end
      if (m_valid_o) begin
        seen = 1'b1;
        if (was_stalled) begin
          $display("Row %0d: m_valid_o rose on a stalled clock edge", r + 1);
          errors++;
        end
      end
    end

    if (mode == MODE_FLUSH) begin
      if (seen) begin
        $display("Row %0d: m_valid_o rose although the operation was flushed", r + 1);
        errors++;
      end
      check(r + 1, "reg_write_mem_o", 0, reg_write_mem_o);
      check(r + 1, "trap_mem_o", 0, trap_mem_o);
    end else if (!seen) begin
      $display("Row %0d: m_valid_o never rose for this operation", r + 1);
      errors++;
    end else begin
      if (is_div) begin
        check(r + 1, "m_result_mem_o", rows[r][23], m_result_mem_o);
      end else begin
        check(r + 1, "alu_result_mem_o", rows[r][22], alu_result_mem_o);
      end
      check(r + 1, "reg_write_mem_o", rows[r][12], reg_write_mem_o);
      check(r + 1, "rd_mem_o", rows[r][15], rd_mem_o);
      check(r + 1, "jb_tgt_mem_o", rows[r][21], jb_tgt_mem_o);
      check(r + 1, "trap_mem_o", rows[r][24], trap_mem_o);
      check(r + 1, "trap_code_mem_o", rows[r][25], trap_code_mem_o);
      check(r + 1, "op_active_o at end", 0, op_active_o);
    end

    // Valid is a single pulse per operation
    @(posedge clk);
    #1;
    stall_i = 1'b0;
    flush_i = 1'b0;
    @(negedge clk);
    check(r + 1, "m_valid_o single pulse", 0, m_valid_o);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    rst_n        = 1'b0;
    s_valid_i    = 1'b0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    reg_write_i  = 1'b0;
    alu_a_src_i  = '0;
    alu_b_imm_i  = 1'b0;
    alu_instr_i  = '0;
    funct3_i     = '0;
    funct7_b5_i  = 1'b0;
    op_b5_i      = 1'b0;
    is_branch_i  = 1'b0;
    is_jal_i     = 1'b0;
    is_jalr_i    = 1'b0;
    jb_tgt_src_i = 1'b0;
    is_mc_i      = 1'b0;
    trap_i       = 1'b0;
    trap_code_i  = '0;
    rd_i         = '0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    imm_i        = '0;
    pc_i         = '0;

    read_trace();
    if (n_rows == 0) begin
      $display("Trace file holds no operations");
      errors++;
    end
    cycle_limit = n_rows * (ex_pkg::DIV_CYCLES + 16) + 50;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle outputs straight after reset
    @(negedge clk);
    check(0, "m_valid_o after reset", 0, m_valid_o);
    check(0, "op_active_o after reset", 0, op_active_o);
    check(0, "reg_write_mem_o after reset", 0, reg_write_mem_o);
    check(0, "trap_mem_o after reset", 0, trap_mem_o);

    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               s_valid_i,
  input  logic               stall_i,
  input  logic               flush_i,
  input  logic               reg_write_i,
  input  ex_pkg::alu_a_src_t alu_a_src_i,
  input  logic               alu_b_imm_i,
  input  ex_pkg::alu_instr_t alu_instr_i,
  input  ex_pkg::funct3_t    funct3_i,
  input  logic               funct7_b5_i,
  input  logic               op_b5_i,
  input  logic               is_branch_i,
  input  logic               is_jal_i,
  input  logic               is_jalr_i,
  input  logic               jb_tgt_src_i,
  input  logic               is_mc_i,
  input  logic               trap_i,
  input  ex_pkg::trap_code_t trap_code_i,
  input  ex_pkg::reg_addr_t  rd_i,
  input  ex_pkg::xlen_t      rs1_data_i,
  input  ex_pkg::xlen_t      rs2_data_i,
  input  ex_pkg::xlen_t      imm_i,
  input  ex_pkg::xlen_t      pc_i,
  output ex_pkg::pc_sel_t    pc_sel_o,
  output ex_pkg::xlen_t      pc_redir_tgt_o,
  output logic               op_active_o,
  output logic               m_valid_o,
  output logic               reg_write_mem_o,
  output logic               trap_mem_o,
  output ex_pkg::trap_code_t trap_code_mem_o,
  output ex_pkg::reg_addr_t  rd_mem_o,
  output ex_pkg::xlen_t      alu_result_mem_o,
  output ex_pkg::xlen_t      m_result_mem_o,
  output ex_pkg::xlen_t      jb_tgt_mem_o
);

  ex_pkg::xlen_t alu_result;
  ex_pkg::xlen_t div_result;
  logic          misalign;
  logic          div_start;
  logic          div_busy;
  logic          valid_next;
  logic          mc_active;

  ex_alu alu_i (
    .alu_a_src_i (alu_a_src_i),
    .alu_b_imm_i (alu_b_imm_i),
    .alu_instr_i (alu_instr_i),
    .funct3_i    (funct3_i),
    .funct7_b5_i (funct7_b5_i),
    .op_b5_i     (op_b5_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .result_o    (alu_result)
  );

  // Redirect target doubles as the registered jump target
  ex_branch branch_i (
    .funct3_i     (funct3_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .alu_result_i (alu_result),
    .is_branch_i  (is_branch_i),
    .is_jal_i     (is_jal_i),
    .is_jalr_i    (is_jalr_i),
    .jb_tgt_src_i (jb_tgt_src_i),
    .taken_o      (),
    .jb_tgt_o     (pc_redir_tgt_o),
    .misalign_o   (misalign),
    .pc_sel_o     (pc_sel_o)
  );

  ex_div div_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .funct3_i   (funct3_i),
    .dividend_i (rs1_data_i),
    .divisor_i  (rs2_data_i),
    .busy_o     (div_busy),
    .result_o   (div_result)
  );

  ex_mc_ctrl mc_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_valid_i    (s_valid_i),
    .is_mc_i      (is_mc_i),
    .stall_i      (stall_i),
    .div_busy_i   (div_busy),
    .div_start_o  (div_start),
    .op_active_o  (op_active_o),
    .mc_active_o  (mc_active),
    .valid_next_o (valid_next)
  );

  ex_mem_reg mem_reg_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .mc_active_i  (mc_active),
    .valid_i      (valid_next),
    .reg_write_i  (reg_write_i),
    .trap_i       (trap_i),
    .misalign_i   (misalign),
    .trap_code_i  (trap_code_i),
    .rd_i         (rd_i),
    .alu_result_i (alu_result),
    .m_result_i   (div_result),
    .jb_tgt_i     (pc_redir_tgt_o),
    .m_valid_o    (m_valid_o),
    .reg_write_o  (reg_write_mem_o),
    .trap_o       (trap_mem_o),
    .trap_code_o  (trap_code_mem_o),
    .rd_o         (rd_mem_o),
    .alu_result_o (alu_result_mem_o),
    .m_result_o   (m_result_mem_o),
    .jb_tgt_o     (jb_tgt_mem_o)
  );

endmodule

//--- ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               flush_i,
  input  logic               mc_active_i,
  input  logic               valid_i,
  input  logic               reg_write_i,
  input  logic               trap_i,
  input  logic               misalign_i,
  input  ex_pkg::trap_code_t trap_code_i,
  input  ex_pkg::reg_addr_t  rd_i,
  input  ex_pkg::xlen_t      alu_result_i,
  input  ex_pkg::xlen_t      m_result_i,
  input  ex_pkg::xlen_t      jb_tgt_i,
  output logic               m_valid_o,
  output logic               reg_write_o,
  output logic               trap_o,
  output ex_pkg::trap_code_t trap_code_o,
  output ex_pkg::reg_addr_t  rd_o,
  output ex_pkg::xlen_t      alu_result_o,
  output ex_pkg::xlen_t      m_result_o,
  output ex_pkg::xlen_t      jb_tgt_o
);

  logic flush;

  // Flush waits until a running divide has handed over its result
  assign flush = flush_i && !mc_active_i;

  // Control fields, bubbled so MEM can act on them without checking valid
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      trap_o      <= 1'b0;
    end else if (!stall_i) begin
      m_valid_o   <= valid_i;
      reg_write_o <= valid_i && reg_write_i;
      trap_o      <= valid_i && (trap_i || misalign_i);
    end
  end

  // Payload fields, may be stale behind a bubble
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      trap_code_o  <= misalign_i ? ex_pkg::TRAP_INSTR_MISALIGN : trap_code_i;
      rd_o         <= rd_i;
      alu_result_o <= alu_result_i;
      m_result_o   <= m_result_i;
      jb_tgt_o     <= jb_tgt_i;
    end
  end

  a_flush_kills_valid: assert property (
    @(posedge clk) disable iff (!rst_n) flush |=> !m_valid_o
  );

endmodule

//--- ex_mc_ctrl.sv
`timescale 1ns/1ps

module ex_mc_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic s_valid_i,
  input  logic is_mc_i,
  input  logic stall_i,
  input  logic div_busy_i,
  output logic div_start_o,
  output logic op_active_o,
  output logic mc_active_o,
  output logic valid_next_o
);

  typedef enum logic [1:0] {
    IDLE,
    MC_EXEC,
    MC_DONE
  } state_t;

  state_t state;
  state_t state_next;
  logic   start;

  // ========================================================================
  // Sequencer for single and multi-cycle operations
  // ========================================================================

  always_comb begin
    state_next   = state;
    valid_next_o = 1'b0;
    op_active_o  = 1'b0;
    start        = 1'b0;
    case (state)
      IDLE: begin
        if (s_valid_i) begin
          if (!is_mc_i) begin
            valid_next_o = 1'b1;
          end else begin
            state_next  = MC_EXEC;
            start       = 1'b1;
            op_active_o = 1'b1;
          end
        end
      end
      MC_EXEC: begin
        // Divider busy rises one cycle after the start pulse
        if (div_busy_i) begin
          op_active_o = 1'b1;
        end else begin
          state_next   = MC_DONE;
          valid_next_o = 1'b1;
        end
      end
      MC_DONE: begin
        // Back to back divides skip IDLE
        if (s_valid_i && is_mc_i) begin
          state_next  = MC_EXEC;
          start       = 1'b1;
          op_active_o = 1'b1;
        end else begin
          state_next   = IDLE;
          valid_next_o = s_valid_i;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // Holding state under stall keeps a finished result in MC_EXEC
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (!stall_i) begin
      state <= state_next;
    end
  end

  assign div_start_o = start && !stall_i;
  assign mc_active_o = op_active_o || (state != IDLE);

  a_stall_holds_state: assert property (
    @(posedge clk) disable iff (!rst_n) stall_i |=> $stable(state)
  );

endmodule

//--- ex_div.sv
`timescale 1ns/1ps

module ex_div (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  ex_pkg::funct3_t funct3_i,
  input  ex_pkg::xlen_t   dividend_i,
  input  ex_pkg::xlen_t   divisor_i,
  output logic            busy_o,
  output ex_pkg::xlen_t   result_o
);

  logic                  sgn;
  logic                  rem_sel;
  ex_pkg::xlen_t         a_mag;
  ex_pkg::xlen_t         b_mag;
  ex_pkg::div_cnt_t      cnt;
  ex_pkg::xlen_t         quo;
  ex_pkg::xlen_t         rmd;
  ex_pkg::xlen_t         dsr;
  logic                  neg_q;
  logic                  neg_r;
  logic                  rem_q;
  logic [ex_pkg::XLEN:0] rmd_sh;
  logic [ex_pkg::XLEN:0] trial;

  always_comb begin
    case (funct3_i)
      ex_pkg::FUNCT3_DIV:  {sgn, rem_sel} = 2'b10;
      ex_pkg::FUNCT3_DIVU: {sgn, rem_sel} = 2'b00;
      ex_pkg::FUNCT3_REM:  {sgn, rem_sel} = 2'b11;
      ex_pkg::FUNCT3_REMU: {sgn, rem_sel} = 2'b01;
      default:             {sgn, rem_sel} = 2'b00;
    endcase
  end

  // Magnitudes, the most negative value maps onto itself as unsigned
  assign a_mag = (sgn && dividend_i[ex_pkg::XLEN-1]) ? -dividend_i : dividend_i;
  assign b_mag = (sgn && divisor_i[ex_pkg::XLEN-1]) ? -divisor_i : divisor_i;

  // Shift one dividend bit into the partial remainder and try a subtract
  assign rmd_sh = {rmd, quo[ex_pkg::XLEN-1]};
  assign trial  = rmd_sh - {1'b0, dsr};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_o <= 1'b0;
      cnt    <= '0;
    end else if (start_i) begin
      busy_o <= 1'b1;
      cnt    <= ex_pkg::div_cnt_t'(ex_pkg::DIV_CYCLES);
    end else if (busy_o) begin
      cnt <= cnt - 1'b1;
      if (cnt == ex_pkg::div_cnt_t'(1)) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Datapath, quotient bits enter at the bottom as dividend bits leave the top
  always_ff @(posedge clk) begin
    if (start_i) begin
      quo   <= a_mag;
      rmd   <= '0;
      dsr   <= b_mag;
      // Divide by zero keeps the all ones quotient unsigned
      neg_q <= sgn && (dividend_i[ex_pkg::XLEN-1] ^ divisor_i[ex_pkg::XLEN-1])
               && (|divisor_i);
      // Remainder takes the sign of the dividend
      neg_r <= sgn && dividend_i[ex_pkg::XLEN-1];
      rem_q <= rem_sel;
    end else if (busy_o) begin
      if (!trial[ex_pkg::XLEN]) begin
        rmd <= trial[ex_pkg::XLEN-1:0];
        quo <= {quo[ex_pkg::XLEN-2:0], 1'b1};
      end else begin
        rmd <= rmd_sh[ex_pkg::XLEN-1:0];
        quo <= {quo[ex_pkg::XLEN-2:0], 1'b0};
      end
    end
  end

  // Overflow case falls out naturally, quotient 0x8000_0000 and remainder 0
  assign result_o = rem_q ? (neg_r ? -rmd : rmd) : (neg_q ? -quo : quo);

  // Sequencer must wait for completion before the next divide
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) start_i |-> !busy_o
  );

endmodule

//--- ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
  input  ex_pkg::funct3_t funct3_i,
  input  ex_pkg::xlen_t   rs1_data_i,
  input  ex_pkg::xlen_t   rs2_data_i,
  input  ex_pkg::xlen_t   imm_i,
  input  ex_pkg::xlen_t   pc_i,
  input  ex_pkg::xlen_t   alu_result_i,
  input  logic            is_branch_i,
  input  logic            is_jal_i,
  input  logic            is_jalr_i,
  input  logic            jb_tgt_src_i,
  output logic            taken_o,
  output ex_pkg::xlen_t   jb_tgt_o,
  output logic            misalign_o,
  output ex_pkg::pc_sel_t pc_sel_o
);

  logic eq;
  logic lt;
  logic ltu;
  logic jb_active;

  // Branch compare
  assign eq  = (rs1_data_i == rs2_data_i);
  assign lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign ltu = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (funct3_i)
      ex_pkg::FUNCT3_BEQ:  taken_o = eq;
      ex_pkg::FUNCT3_BNE:  taken_o = !eq;
      ex_pkg::FUNCT3_BLT:  taken_o = lt;
      ex_pkg::FUNCT3_BGE:  taken_o = !lt;
      ex_pkg::FUNCT3_BLTU: taken_o = ltu;
      ex_pkg::FUNCT3_BGEU: taken_o = !ltu;
      // Codes 2 and 3 are not branches
      default:             taken_o = 1'b0;
    endcase
  end

  // Target select
  // JAL and branches use a dedicated pc + imm adder
  // JALR takes rs1 + imm from the ALU with bit 0 forced low
  assign jb_tgt_o = jb_tgt_src_i ? {alu_result_i[ex_pkg::XLEN-1:1], 1'b0}
                                 : pc_i + imm_i;

  // Control transfer happens on a taken branch or any jump
  assign jb_active = (is_branch_i && taken_o) || is_jal_i || is_jalr_i;

  // No compressed instructions, so targets must be word aligned
  assign misalign_o = jb_active && (|jb_tgt_o[1:0]);

  // No prediction, every control transfer redirects from here
  assign pc_sel_o = jb_active ? ex_pkg::PC_SEL_REDIRECT : ex_pkg::PC_SEL_SEQUENTIAL;

endmodule

//--- ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_a_src_t alu_a_src_i,
  input  logic               alu_b_imm_i,
  input  ex_pkg::alu_instr_t alu_instr_i,
  input  ex_pkg::funct3_t    funct3_i,
  input  logic               funct7_b5_i,
  input  logic               op_b5_i,
  input  ex_pkg::xlen_t      rs1_data_i,
  input  ex_pkg::xlen_t      rs2_data_i,
  input  ex_pkg::xlen_t      imm_i,
  input  ex_pkg::xlen_t      pc_i,
  output ex_pkg::xlen_t      result_o
);

  ex_pkg::alu_op_t alu_op;
  ex_pkg::xlen_t   op_a;
  ex_pkg::xlen_t   op_b;
  logic [4:0]      shamt;

  // ========================================================================
  // Operation decode
  // ========================================================================

  always_comb begin
    alu_op = ex_pkg::ADD;
    case (alu_instr_i)
      ex_pkg::ALU_INSTR_ADD: alu_op = ex_pkg::ADD;
      ex_pkg::ALU_INSTR_FUNCT: begin
        case (funct3_i)
          // SUB only exists in the register form, opcode bit 5 set
          3'd0: alu_op = (funct7_b5_i && op_b5_i) ? ex_pkg::SUB : ex_pkg::ADD;
          3'd1: alu_op = ex_pkg::SLL;
          3'd2: alu_op = ex_pkg::SLT;
          3'd3: alu_op = ex_pkg::SLTU;
          3'd4: alu_op = ex_pkg::XOR;
          // Immediate shifts carry funct7 in imm[11:5] too
          3'd5: alu_op = funct7_b5_i ? ex_pkg::SRA : ex_pkg::SRL;
          3'd6: alu_op = ex_pkg::OR;
          default: alu_op = ex_pkg::AND;
        endcase
      end
      // Loads, stores, LUI, AUIPC and jumps all add
      default: alu_op = ex_pkg::ADD;
    endcase
  end

  // Operand select
  always_comb begin
    case (alu_a_src_i)
      ex_pkg::ALU_A_RS1:  op_a = rs1_data_i;
      ex_pkg::ALU_A_ZERO: op_a = '0;
      ex_pkg::ALU_A_PC:   op_a = pc_i;
      default:            op_a = rs1_data_i;
    endcase
  end

  assign op_b  = alu_b_imm_i ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  // ========================================================================
  // ALU
  // ========================================================================

  always_comb begin
    case (alu_op)
      ex_pkg::SUB:  result_o = op_a - op_b;
      ex_pkg::SLL:  result_o = op_a << shamt;
      ex_pkg::SLT:  result_o = {31'd0, $signed(op_a) < $signed(op_b)};
      ex_pkg::SLTU: result_o = {31'd0, op_a < op_b};
      ex_pkg::XOR:  result_o = op_a ^ op_b;
      ex_pkg::SRL:  result_o = op_a >> shamt;
      ex_pkg::SRA:  result_o = $signed(op_a) >>> shamt;
      ex_pkg::OR:   result_o = op_a | op_b;
      ex_pkg::AND:  result_o = op_a & op_b;
      default:      result_o = op_a + op_b;
    endcase
  end

endmodule

//--- ex_pkg.sv
package ex_pkg;

  // ========================================================================
  // Widths and word types
  // ========================================================================

  localparam int XLEN = 32;

  // One divider iteration per result bit
  localparam int DIV_CYCLES = XLEN;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [1:0]      trap_code_t;

  // Divider iteration counter, wide enough to hold DIV_CYCLES
  typedef logic [$clog2(DIV_CYCLES+1)-1:0] div_cnt_t;

  localparam trap_code_t TRAP_INSTR_MISALIGN = 2'd0;

  // ========================================================================
  // Decode encodings
  // ========================================================================

  // A operand source, code 3 falls back to rs1
  typedef logic [1:0] alu_a_src_t;
  localparam alu_a_src_t ALU_A_RS1  = 2'd0;
  localparam alu_a_src_t ALU_A_ZERO = 2'd1;
  localparam alu_a_src_t ALU_A_PC   = 2'd2;

  // ALU decode class, anything but FUNCT adds
  typedef logic [1:0] alu_instr_t;
  localparam alu_instr_t ALU_INSTR_ADD   = 2'd0;
  localparam alu_instr_t ALU_INSTR_FUNCT = 2'd2;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_t;

  // Code 1 belongs to the predicted path of a fetch unit with prediction
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'd0,
    PC_SEL_REDIRECT   = 2'd2
  } pc_sel_t;

  // Branch compare funct3
  localparam funct3_t FUNCT3_BEQ  = 3'd0;
  localparam funct3_t FUNCT3_BNE  = 3'd1;
  localparam funct3_t FUNCT3_BLT  = 3'd4;
  localparam funct3_t FUNCT3_BGE  = 3'd5;
  localparam funct3_t FUNCT3_BLTU = 3'd6;
  localparam funct3_t FUNCT3_BGEU = 3'd7;

  // RV32M divide and remainder funct3
  localparam funct3_t FUNCT3_DIV  = 3'd4;
  localparam funct3_t FUNCT3_DIVU = 3'd5;
  localparam funct3_t FUNCT3_REM  = 3'd6;
  localparam funct3_t FUNCT3_REMU = 3'd7;

endpackage
